/* source/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Fetch and line widths
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_DATA_WIDTH 128

// Geometry
`define ICACHE_NB_WAYS    4
`define ICACHE_NB_SETS    16

// Address fields, one line per 128-bit fetch word
`define ICACHE_SET_WIDTH  4
`define ICACHE_SET_LSB    4
`define ICACHE_TAG_LSB    8
`define ICACHE_TAG_WIDTH  7

// Replacement
`define ICACHE_LFSR_WIDTH 8

`endif

/* source/icache_pkg.sv */
`include "icache_defines.svh"
`default_nettype none

package icache_pkg;

   // Controller states
   typedef enum logic [2:0]
   {
      DISABLED,
      FLUSH_ALL,
      FLUSH_SET,
      IDLE,
      LOOKUP,
      WAIT_REFILL
   } icache_state_e;

   typedef logic [`ICACHE_NB_WAYS-1:0]   way_mask_t;
   typedef logic [`ICACHE_SET_WIDTH-1:0] set_idx_t;

   // Valid bit sits on top of the address tag
   typedef logic [`ICACHE_TAG_WIDTH:0]   tag_t;

endpackage

`default_nettype wire

/* source/icache_way_array.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_way_array
   import icache_pkg::*;
(
   input  logic                                              clk,
   input  logic                                              rst_n,

   input  logic                                              rd_en_i,
   input  set_idx_t                                          rd_set_i,
   output tag_t [`ICACHE_NB_WAYS-1:0]                        rd_tags_o,
   output logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_WIDTH-1:0] rd_data_o,

   input  way_mask_t                                         wr_ways_i,
   input  set_idx_t                                          wr_set_i,
   input  tag_t                                              wr_tag_i,
   input  logic [`ICACHE_DATA_WIDTH-1:0]                     wr_data_i,
   input  logic                                              wr_data_en_i
);

   tag_t                          tag_q  [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];
   logic [`ICACHE_DATA_WIDTH-1:0] data_q [`ICACHE_NB_WAYS][`ICACHE_NB_SETS];

   // Tag storage, all entries invalid out of reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int w = 0; w < `ICACHE_NB_WAYS; w++)
         begin
            for (int s = 0; s < `ICACHE_NB_SETS; s++)
            begin
               tag_q[w][s] <= '0;
            end
         end
         rd_tags_o <= '0;
      end
      else
      begin
         for (int w = 0; w < `ICACHE_NB_WAYS; w++)
         begin
            if (wr_ways_i[w])
               tag_q[w][wr_set_i] <= wr_tag_i;
            if (rd_en_i)
               rd_tags_o[w] <= tag_q[w][rd_set_i];
         end
      end
   end

   // Line storage, flushes leave it untouched
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (wr_ways_i[w] && wr_data_en_i)
            data_q[w][wr_set_i] <= wr_data_i;
         if (rd_en_i)
            rd_data_o[w] <= data_q[w][rd_set_i];
      end
   end

endmodule

`default_nettype wire

/* source/icache_lookup_stage.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_lookup_stage
(
   input  logic                          clk,
   input  logic                          rst_n,

   input  logic                          lookup_en_i,
   input  logic                          lookup_clr_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr_i,

   output logic                          lookup_valid_o,
   output logic [`ICACHE_ADDR_WIDTH-1:0] lookup_addr_o
);

   logic                          valid_q;
   logic [`ICACHE_ADDR_WIDTH-1:0] addr_q;

   //////////////////////
   // Request in flight
   //////////////////////

   // Set by a grant, dropped once the fetch has been answered.
   // A new grant in the same cycle as a clear keeps it set
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (lookup_en_i)
      begin
         valid_q <= 1'b1;
      end
      else if (lookup_clr_i)
      begin
         valid_q <= 1'b0;
      end
   end

   // Granted address, held through a refill
   always_ff @(posedge clk)
   begin
      if (lookup_en_i)
         addr_q <= fetch_addr_i;
   end

   assign lookup_valid_o = valid_q;
   assign lookup_addr_o  = addr_q;

endmodule

`default_nettype wire

/* source/icache_tag_compare.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_tag_compare
   import icache_pkg::*;
(
   input  logic                                              clk,
   input  logic                                              rst_n,

   input  tag_t [`ICACHE_NB_WAYS-1:0]                        rd_tags_i,
   input  logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_WIDTH-1:0] rd_data_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0]                     lookup_addr_i,
   input  logic                                              victim_adv_i,

   output logic                                              hit_o,
   output logic [`ICACHE_DATA_WIDTH-1:0]                     hit_data_o,
   output way_mask_t                                         victim_way_o
);

   localparam int WAY_IDX_W = $clog2(`ICACHE_NB_WAYS);

   way_mask_t                      way_valid;
   way_mask_t                      way_match;
   logic [WAY_IDX_W-1:0]           free_idx;
   logic [`ICACHE_LFSR_WIDTH-1:0]  lfsr_q;
   logic                           lfsr_fb;

   //////////////////////
   // Way match
   //////////////////////

   always_comb
   begin
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         way_valid[w] = rd_tags_i[w][`ICACHE_TAG_WIDTH];
         way_match[w] = way_valid[w] &&
                        (rd_tags_i[w][`ICACHE_TAG_WIDTH-1:0] ==
                         lookup_addr_i[`ICACHE_TAG_LSB +: `ICACHE_TAG_WIDTH]);
      end
   end

   assign hit_o = |way_match;

   // Hit data mux and last free way
   always_comb
   begin
      hit_data_o = '0;
      free_idx   = '0;
      for (int w = 0; w < `ICACHE_NB_WAYS; w++)
      begin
         if (way_match[w])
            hit_data_o = rd_data_i[w];
         if (!way_valid[w])
            free_idx = WAY_IDX_W'(w);
      end
   end

   //////////////////////
   // Victim selection
   //////////////////////

   // x^8 + x^6 + x^5 + x^4 + 1
   assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= '1;
      else if (victim_adv_i && (&way_valid))
         lfsr_q <= {lfsr_q[`ICACHE_LFSR_WIDTH-2:0], lfsr_fb};
   end

   assign victim_way_o = (&way_valid) ? way_mask_t'(1) << lfsr_q[WAY_IDX_W-1:0]
                                      : way_mask_t'(1) << free_idx;

endmodule

`default_nettype wire

/* source/icache_refill_ctrl.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_refill_ctrl
   import icache_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,

   input  logic                          fetch_req_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [`ICACHE_DATA_WIDTH-1:0] fetch_rdata_o,

   input  logic                          bypass_icache_i,
   input  logic                          flush_icache_i,
   input  logic                          flush_set_req_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] flush_set_addr_i,
   output logic                          cache_is_bypassed_o,
   output logic                          cache_is_flushed_o,
   output logic                          flush_set_ack_o,

   input  logic                          lookup_valid_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] lookup_addr_i,
   output logic                          lookup_en_o,
   output logic                          lookup_clr_o,

   input  logic                          hit_i,
   input  logic [`ICACHE_DATA_WIDTH-1:0] hit_data_i,
   input  way_mask_t                     victim_way_i,
   output logic                          victim_adv_o,

   output logic                          refill_req_o,
   output logic [`ICACHE_ADDR_WIDTH-1:0] refill_addr_o,
   input  logic                          refill_gnt_i,
   input  logic                          refill_r_valid_i,
   input  logic [`ICACHE_DATA_WIDTH-1:0] refill_r_data_i,

   output logic                          rd_en_o,
   output set_idx_t                      rd_set_o,
   output way_mask_t                     wr_ways_o,
   output set_idx_t                      wr_set_o,
   output tag_t                          wr_tag_o,
   output logic [`ICACHE_DATA_WIDTH-1:0] wr_data_o,
   output logic                          wr_data_en_o
);

   icache_state_e                 state_q, state_d;
   set_idx_t                      flush_cnt_q;
   way_mask_t                     victim_q;
   logic                          byp_req_q;
   logic                          byp_pend_q;
   logic [`ICACHE_ADDR_WIDTH-1:0] byp_addr_q;
   logic                          byp_gnt;
   logic                          ctrl_req;

   assign ctrl_req = bypass_icache_i | flush_icache_i | flush_set_req_i;
   assign byp_gnt  = fetch_gnt_o & (state_q == DISABLED);

   //////////////////////
   // State registers
   //////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= DISABLED;
         flush_cnt_q <= '0;
         victim_q    <= '0;
         byp_req_q   <= 1'b0;
         byp_pend_q  <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= (state_q == FLUSH_ALL) ? flush_cnt_q + 1'b1 : '0;
         if (victim_adv_o)
            victim_q <= victim_way_i;

         // A forwarded fetch keeps the cache bypassed until its data returns
         if (byp_gnt)
            byp_pend_q <= 1'b1;
         else if (refill_r_valid_i)
            byp_pend_q <= 1'b0;

         if (byp_gnt)
            byp_req_q <= 1'b1;
         else if (refill_gnt_i)
            byp_req_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (byp_gnt)
         byp_addr_q <= fetch_addr_i;
   end

   //////////////////////
   // Next state
   //////////////////////

   always_comb
   begin
      state_d             = state_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_r_data_i;
      refill_req_o        = 1'b0;
      refill_addr_o       = lookup_addr_i;
      lookup_en_o         = 1'b0;
      lookup_clr_o        = 1'b0;
      victim_adv_o        = 1'b0;
      rd_en_o             = 1'b0;
      rd_set_o            = fetch_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_WIDTH];
      wr_ways_o           = '0;
      wr_set_o            = lookup_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_WIDTH];
      wr_tag_o            = '0;
      wr_data_o           = refill_r_data_i;
      wr_data_en_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_set_ack_o     = 1'b1;
            lookup_clr_o        = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;
            if (bypass_icache_i || byp_pend_q)
            begin
               fetch_gnt_o   = fetch_req_i & bypass_icache_i;
               refill_req_o  = byp_req_q;
               refill_addr_o = byp_addr_q;
            end
            else
            begin
               state_d = FLUSH_ALL;
            end
         end

         FLUSH_ALL:
         begin
            flush_set_ack_o = 1'b1;
            wr_ways_o       = '1;
            wr_set_o        = flush_cnt_q;
            if (flush_cnt_q == set_idx_t'(`ICACHE_NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = IDLE;
            end
         end

         FLUSH_SET:
         begin
            flush_set_ack_o = 1'b1;
            wr_ways_o       = '1;
            wr_set_o        = flush_set_addr_i[`ICACHE_SET_LSB +: `ICACHE_SET_WIDTH];
            state_d         = IDLE;
         end

         IDLE:
         begin
            fetch_gnt_o = fetch_req_i & ~ctrl_req;
            rd_en_o     = fetch_gnt_o;
            lookup_en_o = fetch_gnt_o;
            if (bypass_icache_i)
               state_d = DISABLED;
            else if (flush_icache_i)
               state_d = FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = FLUSH_SET;
            else if (fetch_req_i)
               state_d = LOOKUP;
         end

         LOOKUP:
         begin
            if (!lookup_valid_i)
            begin
               state_d = IDLE;
            end
            else if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = hit_data_i;
               // Next lookup overlaps the hit being returned
               fetch_gnt_o    = fetch_req_i & ~ctrl_req;
               rd_en_o        = fetch_gnt_o;
               lookup_en_o    = fetch_gnt_o;
               if (!fetch_gnt_o)
               begin
                  lookup_clr_o = 1'b1;
                  state_d      = IDLE;
               end
            end
            else
            begin
               refill_req_o = 1'b1;
               victim_adv_o = refill_gnt_i;
               if (refill_gnt_i)
                  state_d = WAIT_REFILL;
            end
         end

         WAIT_REFILL:
         begin
            fetch_rvalid_o = refill_r_valid_i;
            wr_ways_o      = victim_q & {`ICACHE_NB_WAYS{refill_r_valid_i}};
            wr_tag_o       = {1'b1, lookup_addr_i[`ICACHE_TAG_LSB +: `ICACHE_TAG_WIDTH]};
            wr_data_en_o   = 1'b1;
            if (refill_r_valid_i)
            begin
               lookup_clr_o = 1'b1;
               state_d      = IDLE;
            end
         end

         default:
         begin
            state_d = DISABLED;
         end
      endcase
   end

endmodule

`default_nettype wire

/* source/icache_top.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_top
(
   input  logic                          clk,
   input  logic                          rst_n,

   input  logic                          fetch_req_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [`ICACHE_DATA_WIDTH-1:0] fetch_rdata_o,

   output logic                          refill_req_o,
   output logic [`ICACHE_ADDR_WIDTH-1:0] refill_addr_o,
   input  logic                          refill_gnt_i,
   input  logic                          refill_r_valid_i,
   input  logic [`ICACHE_DATA_WIDTH-1:0] refill_r_data_i,

   input  logic                          bypass_icache_i,
   input  logic                          flush_icache_i,
   input  logic                          flush_set_req_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] flush_set_addr_i,
   output logic                          cache_is_bypassed_o,
   output logic                          cache_is_flushed_o,
   output logic                          flush_set_ack_o
);

   logic                                               lookup_en;
   logic                                               lookup_clr;
   logic                                               lookup_valid;
   logic [`ICACHE_ADDR_WIDTH-1:0]                      lookup_addr;

   logic                                               hit;
   logic [`ICACHE_DATA_WIDTH-1:0]                      hit_data;
   logic [`ICACHE_NB_WAYS-1:0]                         victim_way;
   logic                                               victim_adv;

   // Array ports
   logic                                               rd_en;
   logic [`ICACHE_SET_WIDTH-1:0]                       rd_set;
   logic [`ICACHE_NB_WAYS-1:0][`ICACHE_TAG_WIDTH:0]    rd_tags;
   logic [`ICACHE_NB_WAYS-1:0][`ICACHE_DATA_WIDTH-1:0] rd_data;
   logic [`ICACHE_NB_WAYS-1:0]                         wr_ways;
   logic [`ICACHE_SET_WIDTH-1:0]                       wr_set;
   logic [`ICACHE_TAG_WIDTH:0]                         wr_tag;
   logic [`ICACHE_DATA_WIDTH-1:0]                      wr_data;
   logic                                               wr_data_en;

   icache_lookup_stage u_lookup_stage
   (
      .clk            ( clk          ),
      .rst_n          ( rst_n        ),
      .lookup_en_i    ( lookup_en    ),
      .lookup_clr_i   ( lookup_clr   ),
      .fetch_addr_i   ( fetch_addr_i ),
      .lookup_valid_o ( lookup_valid ),
      .lookup_addr_o  ( lookup_addr  )
   );

   icache_tag_compare u_tag_compare
   (
      .clk           ( clk         ),
      .rst_n         ( rst_n       ),
      .rd_tags_i     ( rd_tags     ),
      .rd_data_i     ( rd_data     ),
      .lookup_addr_i ( lookup_addr ),
      .victim_adv_i  ( victim_adv  ),
      .hit_o         ( hit         ),
      .hit_data_o    ( hit_data    ),
      .victim_way_o  ( victim_way  )
   );

   icache_refill_ctrl u_refill_ctrl
   (
      .clk                 ( clk                 ),
      .rst_n               ( rst_n               ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .flush_icache_i      ( flush_icache_i      ),
      .flush_set_req_i     ( flush_set_req_i     ),
      .flush_set_addr_i    ( flush_set_addr_i    ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .flush_set_ack_o     ( flush_set_ack_o     ),
      .lookup_valid_i      ( lookup_valid        ),
      .lookup_addr_i       ( lookup_addr         ),
      .lookup_en_o         ( lookup_en           ),
      .lookup_clr_o        ( lookup_clr          ),
      .hit_i               ( hit                 ),
      .hit_data_i          ( hit_data            ),
      .victim_way_i        ( victim_way          ),
      .victim_adv_o        ( victim_adv          ),
      .refill_req_o        ( refill_req_o        ),
      .refill_addr_o       ( refill_addr_o       ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .refill_r_valid_i    ( refill_r_valid_i    ),
      .refill_r_data_i     ( refill_r_data_i     ),
      .rd_en_o             ( rd_en               ),
      .rd_set_o            ( rd_set              ),
      .wr_ways_o           ( wr_ways             ),
      .wr_set_o            ( wr_set              ),
      .wr_tag_o            ( wr_tag              ),
      .wr_data_o           ( wr_data             ),
      .wr_data_en_o        ( wr_data_en          )
   );

   icache_way_array u_way_array
   (
      .clk          ( clk        ),
      .rst_n        ( rst_n      ),
      .rd_en_i      ( rd_en      ),
      .rd_set_i     ( rd_set     ),
      .rd_tags_o    ( rd_tags    ),
      .rd_data_o    ( rd_data    ),
      .wr_ways_i    ( wr_ways    ),
      .wr_set_i     ( wr_set     ),
      .wr_tag_i     ( wr_tag     ),
      .wr_data_i    ( wr_data    ),
      .wr_data_en_i ( wr_data_en )
   );

endmodule

`default_nettype wire

/* testbench/icache_mem_model.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_mem_model
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          refill_req_i,
   input  logic [`ICACHE_ADDR_WIDTH-1:0] refill_addr_i,
   output logic                          refill_gnt_o,
   output logic                          refill_r_valid_o,
   output logic [`ICACHE_DATA_WIDTH-1:0] refill_r_data_o,
   output int                            refill_count_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_LATENCY = 2;
   localparam int NB_WORDS     = `ICACHE_DATA_WIDTH / 32;

   int                            seed;
   int                            gnt_delay;
   int                            lat_cnt;
   logic                          waiting;
   logic                          busy;
   logic [`ICACHE_ADDR_WIDTH-1:0] line_addr;

   // Outputs change on the falling edge, the cache samples them on the rising edge
   always @(negedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         seed             = 32'hd750b923;
         gnt_delay        = 0;
         lat_cnt          = 0;
         waiting          = 1'b0;
         busy             = 1'b0;
         line_addr        = '0;
         refill_count_o   <= 0;
         refill_gnt_o     <= 1'b0;
         refill_r_valid_o <= 1'b0;
         refill_r_data_o  <= '0;
      end
      else
      begin
         refill_gnt_o     <= 1'b0;
         refill_r_valid_o <= 1'b0;

         // Granted line returns a fixed number of cycles after its grant
         if (busy)
         begin
            lat_cnt = lat_cnt - 1;
            if (lat_cnt == 0)
            begin
               busy             = 1'b0;
               refill_r_valid_o <= 1'b1;
               for (int i = 0; i < NB_WORDS; i++)
                  refill_r_data_o[32*i +: 32] <= line_addr + i;
            end
         end
         else if (refill_req_i)
         begin
            // New request, draw its grant delay of 0 to 3 cycles
            if (!waiting)
            begin
               waiting   = 1'b1;
               gnt_delay = $unsigned($random(seed)) % 4;
            end
            if (gnt_delay == 0)
            begin
               waiting        = 1'b0;
               busy           = 1'b1;
               lat_cnt        = DATA_LATENCY;
               line_addr      = refill_addr_i & ~32'hf;
               refill_gnt_o   <= 1'b1;
               refill_count_o <= refill_count_o + 1;
            end
            else
            begin
               gnt_delay = gnt_delay - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/icache_tb.sv */
`include "icache_defines.svh"
`default_nettype none

module icache_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   // About 20 fetches of at most 10 cycles and two 16-cycle flushes
   // fit well inside this limit
   localparam int TIMEOUT_CYCLES = 3000;

   // A and B sit in sets 2 and 4 and the replacement lines all in set 5
   localparam logic [31:0] ADDR_A    = 32'h0000_0120;
   localparam logic [31:0] ADDR_B    = 32'h0000_3a40;
   localparam logic [31:0] REPL_BASE = 32'h0000_3050;

   logic                          clk;
   logic                          rst_n;
   logic                          fetch_req;
   logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr;
   logic                          fetch_gnt;
   logic                          fetch_rvalid;
   logic [`ICACHE_DATA_WIDTH-1:0] fetch_rdata;
   logic                          refill_req;
   logic [`ICACHE_ADDR_WIDTH-1:0] refill_addr;
   logic                          refill_gnt;
   logic                          refill_r_valid;
   logic [`ICACHE_DATA_WIDTH-1:0] refill_r_data;
   logic                          bypass;
   logic                          flush;
   logic                          flush_set_req;
   logic [`ICACHE_ADDR_WIDTH-1:0] flush_set_addr;
   logic                          cache_is_bypassed;
   logic                          cache_is_flushed;
   logic                          flush_set_ack;
   int                            refill_count;
   int                            error_count;
   int                            fetch_count;
   int                            cycle_count;

   icache_top u_icache_top
   (
      .clk                 ( clk               ),
      .rst_n               ( rst_n             ),
      .fetch_req_i         ( fetch_req         ),
      .fetch_addr_i        ( fetch_addr        ),
      .fetch_gnt_o         ( fetch_gnt         ),
      .fetch_rvalid_o      ( fetch_rvalid      ),
      .fetch_rdata_o       ( fetch_rdata       ),
      .refill_req_o        ( refill_req        ),
      .refill_addr_o       ( refill_addr       ),
      .refill_gnt_i        ( refill_gnt        ),
      .refill_r_valid_i    ( refill_r_valid    ),
      .refill_r_data_i     ( refill_r_data     ),
      .bypass_icache_i     ( bypass            ),
      .flush_icache_i      ( flush             ),
      .flush_set_req_i     ( flush_set_req     ),
      .flush_set_addr_i    ( flush_set_addr    ),
      .cache_is_bypassed_o ( cache_is_bypassed ),
      .cache_is_flushed_o  ( cache_is_flushed  ),
      .flush_set_ack_o     ( flush_set_ack     )
   );

   icache_mem_model u_mem_model
   (
      .clk              ( clk            ),
      .rst_n            ( rst_n          ),
      .refill_req_i     ( refill_req     ),
      .refill_addr_i    ( refill_addr    ),
      .refill_gnt_o     ( refill_gnt     ),
      .refill_r_valid_o ( refill_r_valid ),
      .refill_r_data_o  ( refill_r_data  ),
      .refill_count_o   ( refill_count   )
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("ERROR: timeout after %0d cycles, a fetch or flush never finished", cycle_count);
      $display("Result: FAILED");
      $finish;
   end

   //////////////////////
   // Helpers
   //////////////////////

   // Word i of a line holds the line address plus i
   function automatic logic [127:0] line_data(input logic [31:0] addr);
      logic [31:0] base;
      base = addr & ~32'hf;
      for (int i = 0; i < 4; i++)
         line_data[32*i +: 32] = base + i;
   endfunction

   task automatic report_mismatch(input string test, input logic [127:0] expected,
                                  input logic [127:0] actual);
      error_count++;
      $display("CHECK FAILED: %s expected %0h actual %0h", test, expected, actual);
   endtask

   task automatic report_error(input string what);
      error_count++;
      $display("ERROR: %s", what);
   endtask

   task automatic wait_flush_done();
      do
         @(posedge clk);
      while (cache_is_bypassed || !cache_is_flushed);
   endtask

   // One fetch checked against the line rule and the expected number of refills
   task automatic fetch_and_check(input logic [31:0] addr, input int new_refills,
                                  input string test);
      int count_before;
      count_before = refill_count;
      @(negedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= addr;
      do
         @(posedge clk);
      while (!fetch_gnt);
      @(negedge clk);
      fetch_req <= 1'b0;
      do
         @(posedge clk);
      while (!fetch_rvalid);
      fetch_count++;
      if (fetch_rdata !== line_data(addr))
         report_mismatch({test, " data"}, line_data(addr), fetch_rdata);
      if (refill_count - count_before != new_refills)
         report_mismatch({test, " refills"}, 128'(new_refills),
                         128'(refill_count - count_before));
   endtask

   // Two cached lines with the second granted while the first hit returns
   task automatic back_to_back_hits(input logic [31:0] addr_a, input logic [31:0] addr_b,
                                    input string test);
      int   count_before;
      logic second_gnt;
      count_before = refill_count;
      @(negedge clk);
      fetch_req  <= 1'b1;
      fetch_addr <= addr_a;
      do
         @(posedge clk);
      while (!fetch_gnt);
      @(negedge clk);
      fetch_addr <= addr_b;
      @(posedge clk);
      second_gnt = fetch_gnt;
      if (!fetch_rvalid)
         report_error({test, ": first hit did not return one cycle after its grant"});
      else if (fetch_rdata !== line_data(addr_a))
         report_mismatch({test, " first data"}, line_data(addr_a), fetch_rdata);
      if (!second_gnt)
         report_error({test, ": second fetch was not granted next to the first hit"});
      @(negedge clk);
      fetch_req <= 1'b0;
      if (second_gnt)
      begin
         do
            @(posedge clk);
         while (!fetch_rvalid);
         if (fetch_rdata !== line_data(addr_b))
            report_mismatch({test, " second data"}, line_data(addr_b), fetch_rdata);
      end
      fetch_count += 2;
      if (refill_count != count_before)
         report_mismatch({test, " refills"}, 128'(0), 128'(refill_count - count_before));
   endtask

   //////////////////////
   // Directed tests
   //////////////////////

   task automatic bypass_fetches();
      @(posedge clk);
      if (!cache_is_bypassed)
         report_error("bypass: cache does not report bypass after reset");
      fetch_and_check(ADDR_A, 1, "bypass A");
      fetch_and_check(ADDR_B, 1, "bypass B");
      fetch_and_check(ADDR_A, 1, "bypass A again");
   endtask

   task automatic miss_then_hit();
      @(negedge clk);
      bypass <= 1'b0;
      wait_flush_done();
      fetch_and_check(ADDR_A, 1, "miss A");
      fetch_and_check(ADDR_A, 0, "hit A");
      fetch_and_check(ADDR_B, 1, "miss B");
      back_to_back_hits(ADDR_A, ADDR_B, "back-to-back A B");
      back_to_back_hits(ADDR_B, ADDR_A, "back-to-back B A");
   endtask

   task automatic flush_all_refetch();
      @(negedge clk);
      flush <= 1'b1;
      wait_flush_done();
      @(negedge clk);
      flush <= 1'b0;
      fetch_and_check(ADDR_A, 1, "flush all refetch A");
   endtask

   task automatic flush_set_refetch();
      fetch_and_check(ADDR_B, 1, "set flush fill B");
      @(negedge clk);
      flush_set_req  <= 1'b1;
      flush_set_addr <= ADDR_A;
      do
         @(posedge clk);
      while (!flush_set_ack);
      @(negedge clk);
      flush_set_req <= 1'b0;
      fetch_and_check(ADDR_A, 1, "set flush refetch A");
      fetch_and_check(ADDR_B, 0, "set flush hit B");
   endtask

   // Five tags in one four-way set so the last one forces an eviction
   task automatic fill_and_replace();
      for (int t = 0; t < 5; t++)
         fetch_and_check(REPL_BASE + (t << 8), 1, $sformatf("replace fill %0d", t));
      fetch_and_check(REPL_BASE + (4 << 8), 0, "replace hit last");
   endtask

   initial
   begin
      rst_n          <= 1'b0;
      fetch_req      <= 1'b0;
      fetch_addr     <= '0;
      bypass         <= 1'b1;
      flush          <= 1'b0;
      flush_set_req  <= 1'b0;
      flush_set_addr <= '0;
      error_count = 0;
      fetch_count = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;

      bypass_fetches();
      miss_then_hit();
      flush_all_refetch();
      flush_set_refetch();
      fill_and_replace();

      $display("Done: %0d fetches, %0d errors", fetch_count, error_count);
      if (error_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/icache_pkg.sv
source/icache_way_array.sv
source/icache_lookup_stage.sv
source/icache_tag_compare.sv
source/icache_refill_ctrl.sv
source/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps -Wall
TOP       = icache_tb
RTL_TOP   = icache_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
